//--- src/mac_ctrl_pkg.sv
// mac transmit control types
package mac_ctrl_pkg;

  // widths with a meaning
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] dur_t;
  typedef logic [8:0]  us_time_t;
  typedef logic [17:0] cycle_cnt_t;
  typedef logic [3:0]  retry_cnt_t;
  typedef logic [63:0] tx_word_t;
  typedef logic [11:0] sig_len_t;
  typedef logic [1:0]  fc_type_t;
  typedef logic [3:0]  fc_subtype_t;

  // frame control type codes
  localparam fc_type_t FC_TYPE_MGMT = 2'b00;
  localparam fc_type_t FC_TYPE_CTRL = 2'b01;
  localparam fc_type_t FC_TYPE_DATA = 2'b10;

  // control subtypes
  localparam fc_subtype_t FC_SUB_BAR    = 4'b1000;
  localparam fc_subtype_t FC_SUB_PSPOLL = 4'b1010;
  localparam fc_subtype_t FC_SUB_RTS    = 4'b1011;
  localparam fc_subtype_t FC_SUB_CTS    = 4'b1100;
  localparam fc_subtype_t FC_SUB_ACK    = 4'b1101;

  // fixed frame facts, ack and cts sent at the basic rate
  localparam sig_len_t ACK_LEN_BYTES = 12'd14;
  localparam sig_len_t RTS_LEN_BYTES = 12'd20;
  localparam int ACK_NUM_SYM    = 6;
  localparam int RESP_NUM_WORDS = 3;

  // decoded receive header
  typedef struct packed {
    fc_type_t    fc_type;
    fc_subtype_t fc_subtype;
    logic        more_frag;
    dur_t        duration;
    mac_addr_t   addr1;
    mac_addr_t   addr2;
    sig_len_t    signal_len;
  } rx_hdr_t;

  // request from classifier to responder
  typedef struct packed {
    mac_addr_t ra;
    dur_t      dur_in;
    logic      is_rts;
    logic      inherit_dur;
  } resp_req_t;

  // completion report
  typedef struct packed {
    logic       success;
    retry_cnt_t num_retrans;
  } tx_status_t;

  typedef enum logic [1:0] {RESP_IDLE, RESP_WAIT, RESP_SEND, RESP_DRAIN} resp_state_e;

  typedef enum logic [2:0] {W_IDLE, W_BB_DONE, W_SIG, W_ACK, W_BACKOFF} wait_state_e;

endpackage

//--- src/frame_classifier.sv
// received frame classifier
module frame_classifier (
  input  logic                    clk,
  input  logic                    rstn,
  input  mac_ctrl_pkg::rx_hdr_t   rx_hdr,
  input  logic                    rx_strobe,
  input  logic                    fcs_ok,
  input  logic                    cts_disable,
  input  mac_ctrl_pkg::mac_addr_t self_addr,
  output mac_ctrl_pkg::resp_req_t resp_req,
  output logic                    resp_valid,
  output logic                    ack_seen
);

  logic is_ctrl;
  logic is_data;
  logic is_mgmt;
  logic is_pspoll;
  logic is_bar;
  logic is_rts;
  logic is_ack;
  logic addr_match;
  logic want_resp;

  // type and subtype decode
  assign is_ctrl   = rx_hdr.fc_type == mac_ctrl_pkg::FC_TYPE_CTRL;
  assign is_data   = rx_hdr.fc_type == mac_ctrl_pkg::FC_TYPE_DATA;
  // subtype 14 of management is reserved
  assign is_mgmt   = (rx_hdr.fc_type == mac_ctrl_pkg::FC_TYPE_MGMT) &&
                     (rx_hdr.fc_subtype != 4'b1110);
  assign is_pspoll = is_ctrl && (rx_hdr.fc_subtype == mac_ctrl_pkg::FC_SUB_PSPOLL);
  assign is_bar    = is_ctrl && (rx_hdr.fc_subtype == mac_ctrl_pkg::FC_SUB_BAR);
  // rts and ack also checked against their fixed length
  assign is_rts    = is_ctrl && (rx_hdr.fc_subtype == mac_ctrl_pkg::FC_SUB_RTS) &&
                     (rx_hdr.signal_len == mac_ctrl_pkg::RTS_LEN_BYTES);
  assign is_ack    = is_ctrl && (rx_hdr.fc_subtype == mac_ctrl_pkg::FC_SUB_ACK) &&
                     (rx_hdr.signal_len == mac_ctrl_pkg::ACK_LEN_BYTES);

  // single receiver address test
  assign addr_match = rx_hdr.addr1 == self_addr;

  // frames that earn an ack or cts
  assign want_resp = is_data || is_mgmt || is_pspoll || is_bar || (is_rts && !cts_disable);

  // event pulses, one cycle after the fcs strobe
  always_ff @(posedge clk) begin
    if (!rstn) begin
      resp_valid <= 1'b0;
      ack_seen   <= 1'b0;
    end else begin
      resp_valid <= rx_strobe && fcs_ok && addr_match && want_resp;
      // ack frame only needs the check to be done
      ack_seen   <= rx_strobe && addr_match && is_ack;
    end
  end

  // request payload, taken on every strobe
  always_ff @(posedge clk) begin
    if (rx_strobe) begin
      resp_req.ra          <= rx_hdr.addr2;
      // bit 15 set means an aid, not a duration
      resp_req.dur_in      <= rx_hdr.duration[15] ? '0 : rx_hdr.duration;
      resp_req.is_rts      <= is_rts;
      resp_req.inherit_dur <= is_rts || ((is_data || is_mgmt) && rx_hdr.more_frag);
    end
  end

endmodule

//--- src/ack_responder.sv
// ack and cts responder
module ack_responder #(
  parameter int clk_per_us = 100
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  mac_ctrl_pkg::resp_req_t resp_req,
  input  logic                    resp_valid,
  input  logic                    ack_tx_disable,
  input  logic                    tx_core_busy,
  input  logic                    phy_tx_done,
  input  logic                    credit,
  input  logic [3:0]              resp_rate,
  input  mac_ctrl_pkg::us_time_t  preamble_sig_time,
  input  mac_ctrl_pkg::us_time_t  ofdm_symbol_time,
  input  mac_ctrl_pkg::us_time_t  sifs_time,
  input  mac_ctrl_pkg::dur_t      duration_extra,
  input  mac_ctrl_pkg::us_time_t  send_ack_wait_us,
  output logic                    resp_busy,
  output logic                    start_tx_ack,
  output logic                    word_valid,
  output mac_ctrl_pkg::tx_word_t  tx_word
);

  mac_ctrl_pkg::resp_state_e state;
  mac_ctrl_pkg::resp_req_t   req;
  mac_ctrl_pkg::cycle_cnt_t  wait_cnt;
  mac_ctrl_pkg::cycle_cnt_t  wait_top;
  mac_ctrl_pkg::us_time_t    ack_air;
  mac_ctrl_pkg::dur_t        remain;
  mac_ctrl_pkg::dur_t        resp_dur;
  mac_ctrl_pkg::fc_subtype_t resp_sub;
  logic signed [17:0]        remain_raw;
  logic [1:0]                credit_cnt;
  logic [2:0]                credit_sum;
  logic [1:0]                word_idx;
  logic                      parity;

  assign resp_busy = state != mac_ctrl_pkg::RESP_IDLE;

  // response delay in clock cycles
  assign wait_top = mac_ctrl_pkg::cycle_cnt_t'(send_ack_wait_us * clk_per_us);

  // ack air time at the basic rate
  assign ack_air = preamble_sig_time +
                   mac_ctrl_pkg::us_time_t'(ofdm_symbol_time * mac_ctrl_pkg::ACK_NUM_SYM);

  // peer duration minus our air time and sifs
  assign remain_raw = $signed({2'b00, req.dur_in}) - $signed({9'd0, ack_air}) -
                      $signed({9'd0, sifs_time});
  // negative remainder clamps to zero
  assign remain   = remain_raw[17] ? '0 : remain_raw[15:0];
  assign resp_sub = req.is_rts ? mac_ctrl_pkg::FC_SUB_CTS : mac_ctrl_pkg::FC_SUB_ACK;

  // length 14 holds three ones so the parity is the inverted rate xor
  assign parity = ~^resp_rate;

  // one credit spent per word
  assign word_valid = (state == mac_ctrl_pkg::RESP_SEND) && (credit_cnt != 2'd0);

  // words in order: signal, fc/duration/ra low, ra high
  always_comb begin
    case (word_idx)
      2'd0: tx_word = {32'd0, 14'd0, parity, mac_ctrl_pkg::ACK_LEN_BYTES, 1'b0, resp_rate};
      2'd1: tx_word = {req.ra[31:0], resp_dur, 8'd0, resp_sub,
                       mac_ctrl_pkg::FC_TYPE_CTRL, 2'b00};
      default: tx_word = {48'd0, req.ra[47:32]};
    endcase
  end

  // credit count, saturating
  assign credit_sum = {1'b0, credit_cnt} + {2'b00, credit} - {2'b00, word_valid};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      credit_cnt <= 2'd0;
    end else if (state == mac_ctrl_pkg::RESP_IDLE) begin
      // leftovers dropped while idle
      credit_cnt <= 2'd0;
    end else if (credit_sum > 3'(mac_ctrl_pkg::RESP_NUM_WORDS)) begin
      credit_cnt <= 2'(mac_ctrl_pkg::RESP_NUM_WORDS);
    end else begin
      credit_cnt <= credit_sum[1:0];
    end
  end

  // response fsm
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state        <= mac_ctrl_pkg::RESP_IDLE;
      start_tx_ack <= 1'b0;
      wait_cnt     <= '0;
      word_idx     <= 2'd0;
    end else begin
      start_tx_ack <= 1'b0;
      case (state)
        mac_ctrl_pkg::RESP_IDLE: begin
          wait_cnt <= '0;
          if (resp_valid && !ack_tx_disable) begin
            state <= mac_ctrl_pkg::RESP_WAIT;
          end
        end
        mac_ctrl_pkg::RESP_WAIT: begin
          // own transmission already going, drop the response
          if (tx_core_busy) begin
            state <= mac_ctrl_pkg::RESP_IDLE;
          end else if (wait_cnt == wait_top) begin
            start_tx_ack <= 1'b1;
            word_idx     <= 2'd0;
            state        <= mac_ctrl_pkg::RESP_SEND;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        mac_ctrl_pkg::RESP_SEND: begin
          if (word_valid) begin
            word_idx <= word_idx + 1'b1;
            if (word_idx == 2'(mac_ctrl_pkg::RESP_NUM_WORDS - 1)) begin
              state <= mac_ctrl_pkg::RESP_DRAIN;
            end
          end
        end
        mac_ctrl_pkg::RESP_DRAIN: begin
          // hold until the phy has sent the response
          if (phy_tx_done) begin
            state <= mac_ctrl_pkg::RESP_IDLE;
          end
        end
        default: state <= mac_ctrl_pkg::RESP_IDLE;
      endcase
    end
  end

  // request and duration payload
  always_ff @(posedge clk) begin
    if ((state == mac_ctrl_pkg::RESP_IDLE) && resp_valid) begin
      req <= resp_req;
    end
    resp_dur <= duration_extra + (req.inherit_dur ? remain : '0);
  end

endmodule

//--- src/ack_waiter.sv
// post transmit ack waiter
module ack_waiter #(
  parameter int clk_per_us = 100
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     phy_tx_done,
  input  logic                     resp_busy,
  input  logic                     tx_need_ack,
  input  logic                     bb_end,
  input  logic                     sig_valid,
  input  mac_ctrl_pkg::sig_len_t   sig_len,
  input  logic                     ack_seen,
  input  logic                     backoff_done,
  input  logic                     quit_retrans,
  input  mac_ctrl_pkg::us_time_t   sig_timeout_us,
  input  mac_ctrl_pkg::us_time_t   ack_timeout_adj_us,
  input  mac_ctrl_pkg::retry_cnt_t retrans_limit,
  output logic                     retrans_in_progress,
  output logic                     retrans_trigger,
  output logic                     start_retrans,
  output logic                     tx_complete,
  output mac_ctrl_pkg::tx_status_t tx_status
);

  mac_ctrl_pkg::wait_state_e state;
  mac_ctrl_pkg::cycle_cnt_t  cnt;
  mac_ctrl_pkg::cycle_cnt_t  sig_top;
  mac_ctrl_pkg::cycle_cnt_t  ack_top;
  mac_ctrl_pkg::retry_cnt_t  retry_cnt;
  logic own_done;
  logic sig_ok;
  logic ack_ok;
  logic timed_out;
  logic give_up;
  logic done_noack;
  logic done_ok;
  logic done_fail;

  // timeout limits in cycles
  assign sig_top = mac_ctrl_pkg::cycle_cnt_t'(sig_timeout_us * clk_per_us);
  // ack lasts ACK_NUM_SYM symbols of 4 us
  assign ack_top = mac_ctrl_pkg::cycle_cnt_t'(
                     (mac_ctrl_pkg::ACK_NUM_SYM * 4 + ack_timeout_adj_us) * clk_per_us);

  // a done during a response belongs to the responder
  assign own_done = phy_tx_done && !resp_busy;

  // events inside their windows
  assign sig_ok = sig_valid && (sig_len == mac_ctrl_pkg::ACK_LEN_BYTES) && (cnt < sig_top);
  assign ack_ok = ack_seen && (cnt < ack_top);

  assign timed_out = ((state == mac_ctrl_pkg::W_SIG) && !sig_ok && (cnt == sig_top)) ||
                     ((state == mac_ctrl_pkg::W_ACK) && !ack_ok && (cnt == ack_top));
  assign give_up   = (retry_cnt == retrans_limit) || (retrans_limit == '0);

  // completion conditions
  assign done_noack = (state == mac_ctrl_pkg::W_IDLE) && own_done && !tx_need_ack;
  assign done_ok    = done_noack || ((state == mac_ctrl_pkg::W_ACK) && ack_ok);
  assign done_fail  = (timed_out && give_up) ||
                      ((state == mac_ctrl_pkg::W_BACKOFF) && quit_retrans);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state               <= mac_ctrl_pkg::W_IDLE;
      cnt                 <= '0;
      retry_cnt           <= '0;
      retrans_in_progress <= 1'b0;
      retrans_trigger     <= 1'b0;
      start_retrans       <= 1'b0;
      tx_complete         <= 1'b0;
      tx_status           <= '0;
    end else begin
      retrans_trigger <= 1'b0;
      start_retrans   <= 1'b0;
      tx_complete     <= done_ok || done_fail;

      // status locked until the next completion
      if (done_ok || done_fail) begin
        tx_status.success     <= done_ok;
        tx_status.num_retrans <= done_noack ? '0 : retry_cnt;
        retry_cnt             <= '0;
        retrans_in_progress   <= 1'b0;
      end

      case (state)
        mac_ctrl_pkg::W_IDLE: begin
          if (own_done && tx_need_ack) begin
            retrans_in_progress <= 1'b1;
            state               <= mac_ctrl_pkg::W_BB_DONE;
          end
        end
        mac_ctrl_pkg::W_BB_DONE: begin
          cnt <= '0;
          if (bb_end) begin
            state <= mac_ctrl_pkg::W_SIG;
          end
        end
        mac_ctrl_pkg::W_SIG: begin
          if (sig_ok) begin
            cnt   <= '0;
            state <= mac_ctrl_pkg::W_ACK;
          end else if (!timed_out) begin
            cnt <= cnt + 1'b1;
          end
        end
        mac_ctrl_pkg::W_ACK: begin
          if (ack_ok) begin
            state <= mac_ctrl_pkg::W_IDLE;
          end else if (!timed_out) begin
            cnt <= cnt + 1'b1;
          end
        end
        mac_ctrl_pkg::W_BACKOFF: begin
          if (quit_retrans) begin
            state <= mac_ctrl_pkg::W_IDLE;
          end else if (backoff_done) begin
            // retry in flight, retrans_in_progress stays up
            start_retrans <= 1'b1;
            state         <= mac_ctrl_pkg::W_IDLE;
          end
        end
        default: state <= mac_ctrl_pkg::W_IDLE;
      endcase

      // either timeout ends here
      if (timed_out) begin
        if (give_up) begin
          state <= mac_ctrl_pkg::W_IDLE;
        end else begin
          retry_cnt       <= retry_cnt + 1'b1;
          retrans_trigger <= 1'b1;
          state           <= mac_ctrl_pkg::W_BACKOFF;
        end
      end
    end
  end

endmodule

//--- src/tx_control_top.sv
// mac transmit control top
module tx_control_top #(
  parameter int clk_per_us = 100
) (
  input  logic                     clk,
  input  logic                     rstn,
  // receive results
  input  mac_ctrl_pkg::rx_hdr_t    rx_hdr,
  input  logic                     rx_strobe,
  input  logic                     fcs_ok,
  input  logic                     sig_valid,
  input  mac_ctrl_pkg::sig_len_t   sig_len,
  input  mac_ctrl_pkg::mac_addr_t  self_addr,
  // configuration
  input  logic                     ack_tx_disable,
  input  logic                     cts_disable,
  input  logic [3:0]               resp_rate,
  input  mac_ctrl_pkg::us_time_t   preamble_sig_time,
  input  mac_ctrl_pkg::us_time_t   ofdm_symbol_time,
  input  mac_ctrl_pkg::us_time_t   sifs_time,
  input  mac_ctrl_pkg::dur_t       duration_extra,
  input  mac_ctrl_pkg::us_time_t   send_ack_wait_us,
  input  mac_ctrl_pkg::us_time_t   sig_timeout_us,
  input  mac_ctrl_pkg::us_time_t   ack_timeout_adj_us,
  input  mac_ctrl_pkg::retry_cnt_t retrans_limit,
  // transmit side
  input  logic                     phy_tx_done,
  input  logic                     tx_need_ack,
  input  logic                     tx_core_busy,
  input  logic                     bb_end,
  input  logic                     backoff_done,
  input  logic                     quit_retrans,
  input  logic                     credit,
  output logic                     start_tx_ack,
  output logic                     word_valid,
  output mac_ctrl_pkg::tx_word_t   tx_word,
  output logic                     retrans_in_progress,
  output logic                     retrans_trigger,
  output logic                     start_retrans,
  output logic                     tx_complete,
  output mac_ctrl_pkg::tx_status_t tx_status
);

  mac_ctrl_pkg::resp_req_t resp_req;
  logic resp_valid;
  logic ack_seen;
  logic resp_busy;

  frame_classifier u_classifier (
    .clk, .rstn, .rx_hdr, .rx_strobe, .fcs_ok, .cts_disable, .self_addr,
    .resp_req, .resp_valid, .ack_seen
  );

  // answers frames addressed to us
  ack_responder #(.clk_per_us(clk_per_us)) u_responder (
    .clk, .rstn, .resp_req, .resp_valid, .ack_tx_disable, .tx_core_busy, .phy_tx_done,
    .credit, .resp_rate, .preamble_sig_time, .ofdm_symbol_time, .sifs_time,
    .duration_extra, .send_ack_wait_us,
    .resp_busy, .start_tx_ack, .word_valid, .tx_word
  );

  // waits for the peer ack after our own frames
  ack_waiter #(.clk_per_us(clk_per_us)) u_waiter (
    .clk, .rstn, .phy_tx_done, .resp_busy, .tx_need_ack, .bb_end, .sig_valid, .sig_len,
    .ack_seen, .backoff_done, .quit_retrans, .sig_timeout_us, .ack_timeout_adj_us,
    .retrans_limit,
    .retrans_in_progress, .retrans_trigger, .start_retrans, .tx_complete, .tx_status
  );

endmodule

//--- dv/tx_control_sva.sv
// responder handshake assertions
module tx_control_sva (
  input logic clk,
  input logic rstn,
  input logic resp_busy,
  input logic credit,
  input logic word_valid,
  input logic start_tx_ack
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [2:0] words_sent;
  logic [2:0] credits_seen;

  // words and credits within one response
  always_ff @(posedge clk) begin
    if (!rstn) begin
      words_sent   <= '0;
      credits_seen <= '0;
    end else if (!resp_busy) begin
      // credits offered while idle are lost
      words_sent   <= '0;
      credits_seen <= '0;
    end else begin
      if (word_valid) begin
        words_sent <= words_sent + 1'b1;
      end
      if (credit && (credits_seen != 3'd7)) begin
        credits_seen <= credits_seen + 1'b1;
      end
    end
  end

  // every word needs a credit offered earlier in this response
  a_word_credit: assert property (@(posedge clk) disable iff (!rstn)
    word_valid |-> credits_seen > words_sent)
    else $error("word_valid raised with no credit held");

  // start is a single cycle pulse
  a_start_pulse: assert property (@(posedge clk) disable iff (!rstn)
    start_tx_ack |=> !start_tx_ack)
    else $error("start_tx_ack held longer than one cycle");

  // never more than the three response words
  a_word_limit: assert property (@(posedge clk) disable iff (!rstn)
    word_valid |-> words_sent < 3'(mac_ctrl_pkg::RESP_NUM_WORDS))
    else $error("too many words in one response");

endmodule

bind ack_responder tx_control_sva u_sva (
  .clk(clk), .rstn(rstn), .resp_busy(resp_busy), .credit(credit),
  .word_valid(word_valid), .start_tx_ack(start_tx_ack)
);

//--- dv/tb_tx_control.sv
// transmit control testbench
module tb_tx_control;
  timeunit 1ns;
  timeprecision 1ps;

  // responder rows and waiter rows
  typedef struct packed {
    mac_ctrl_pkg::fc_type_t    fc_type;
    mac_ctrl_pkg::fc_subtype_t fc_sub;
    logic                      more_frag;
    logic                      rand_dur;
    mac_ctrl_pkg::dur_t        dur;
    logic                      to_self;
    logic                      fcs_good;
    logic                      cts_off;
    logic                      exp_resp;
  } resp_case_t;

  typedef struct packed {
    logic                     need_ack;
    logic                     ack_back;
    logic                     give_sig;
    logic                     quit;
    mac_ctrl_pkg::retry_cnt_t limit;
    logic                     exp_success;
    mac_ctrl_pkg::retry_cnt_t exp_retrans;
  } wait_case_t;

  typedef enum int {E_START, E_WORD, E_TRIG, E_RETRY, E_DONE, E_NONE} ev_e;
  typedef enum int {P_CREDIT, P_TX_DONE, P_BB_END, P_SIG, P_BACKOFF, P_QUIT} line_e;

  localparam mac_ctrl_pkg::mac_addr_t SELF_ADDR = 48'h0200_1122_3344;
  localparam mac_ctrl_pkg::mac_addr_t PEER_ADDR = 48'h0a0b_0c0d_0e0f;
  localparam logic [3:0] RATE = 4'hb;
  localparam mac_ctrl_pkg::us_time_t PRE_US = 9'd20;
  localparam mac_ctrl_pkg::us_time_t SYM_US = 9'd4;
  localparam mac_ctrl_pkg::us_time_t SIFS_US = 9'd16;
  localparam mac_ctrl_pkg::dur_t EXTRA = 16'd5;
  localparam mac_ctrl_pkg::fc_type_t T_DATA = mac_ctrl_pkg::FC_TYPE_DATA;
  localparam mac_ctrl_pkg::fc_type_t T_CTRL = mac_ctrl_pkg::FC_TYPE_CTRL;
  localparam mac_ctrl_pkg::fc_type_t T_MGMT = mac_ctrl_pkg::FC_TYPE_MGMT;

  logic clk, rstn, rx_strobe, fcs_ok, sig_valid, cts_disable, phy_tx_done, tx_need_ack;
  logic bb_end, backoff_done, quit_retrans, credit;
  logic start_tx_ack, word_valid, retrans_in_progress, retrans_trigger, start_retrans;
  logic tx_complete;
  mac_ctrl_pkg::rx_hdr_t rx_hdr;
  mac_ctrl_pkg::sig_len_t sig_len;
  mac_ctrl_pkg::retry_cnt_t retrans_limit;
  mac_ctrl_pkg::tx_word_t tx_word;
  mac_ctrl_pkg::tx_status_t tx_status, last_status;
  resp_case_t resp_tab[$];
  wait_case_t wait_tab[$];
  mac_ctrl_pkg::tx_word_t words[$];
  int ev[6];
  int credits, errors, n_checks;

  tx_control_top #(.clk_per_us(2)) dut (
    .*, .self_addr(SELF_ADDR), .ack_tx_disable(1'b0), .tx_core_busy(1'b0),
    .resp_rate(RATE), .preamble_sig_time(PRE_US), .ofdm_symbol_time(SYM_US),
    .sifs_time(SIFS_US), .duration_extra(EXTRA), .send_ack_wait_us(9'd3),
    .sig_timeout_us(9'd10), .ack_timeout_adj_us(9'd2)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks = n_checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // answer duration from the standard rule
  function automatic mac_ctrl_pkg::dur_t exp_duration(input resp_case_t r,
                                                      input mac_ctrl_pkg::dur_t d);
    int rem;
    logic inherit;
    inherit = (r.fc_type == T_CTRL && r.fc_sub == mac_ctrl_pkg::FC_SUB_RTS) ||
              ((r.fc_type == T_DATA || r.fc_type == T_MGMT) && r.more_frag);
    rem = d[15] ? 0 : int'(d);
    rem = rem - (PRE_US + mac_ctrl_pkg::ACK_NUM_SYM * SYM_US) - SIFS_US;
    if (rem < 0 || !inherit) rem = 0;
    return mac_ctrl_pkg::dur_t'(EXTRA + rem);
  endfunction

  task automatic set_line(input line_e which, input logic v);
    case (which)
      P_CREDIT:  credit <= v;
      P_TX_DONE: phy_tx_done <= v;
      P_BB_END:  bb_end <= v;
      P_SIG: begin
        sig_valid <= v;
        sig_len   <= v ? mac_ctrl_pkg::ACK_LEN_BYTES : '0;
      end
      P_BACKOFF: backoff_done <= v;
      default:   quit_retrans <= v;
    endcase
  endtask

  task automatic pulse(input line_e which);
    @(posedge clk);
    set_line(which, 1'b1);
    @(posedge clk);
    set_line(which, 1'b0);
  endtask

  task automatic send_frame(input mac_ctrl_pkg::fc_type_t ty, input mac_ctrl_pkg::fc_subtype_t sub,
                            input logic mf, input mac_ctrl_pkg::dur_t d,
                            input mac_ctrl_pkg::mac_addr_t a1, input mac_ctrl_pkg::sig_len_t len,
                            input logic good);
    @(posedge clk);
    rx_hdr    <= {ty, sub, mf, d, a1, PEER_ADDR, len};
    fcs_ok    <= good;
    rx_strobe <= 1'b1;
    @(posedge clk);
    rx_strobe <= 1'b0;
  endtask

  // wait until the summed event counts reach a target
  task automatic wait_for(input ev_e a, input ev_e b, input int target, input int limit,
                          input string what);
    int n;
    n = 0;
    while ((ev[a] + ev[b] < target) && (n < limit)) begin
      @(posedge clk);
      n = n + 1;
    end
    if (ev[a] + ev[b] < target) begin
      errors = errors + 1;
      $display("ERROR: no %s within %0d cycles", what, limit);
    end
  endtask

  task automatic clear_counts();
    foreach (ev[i]) ev[i] = 0;
    credits = 0;
    words.delete();
  endtask

  // sampled away from the driving edge
  always @(negedge clk) begin
    if (rstn) begin
      if (word_valid) begin
        if (ev[E_WORD] >= credits) begin
          errors = errors + 1;
          $display("ERROR: response word sent before its credit");
        end
        words.push_back(tx_word);
        ev[E_WORD] = ev[E_WORD] + 1;
      end
      if (credit) credits = credits + 1;
      if (start_tx_ack) ev[E_START] = ev[E_START] + 1;
      if (retrans_trigger) ev[E_TRIG] = ev[E_TRIG] + 1;
      if (start_retrans) begin
        ev[E_RETRY] = ev[E_RETRY] + 1;
        // retry still in flight
        check_val("retrans_in_progress", retrans_in_progress, 1);
      end
      if (tx_complete) begin
        ev[E_DONE] = ev[E_DONE] + 1;
        last_status = tx_status;
        check_val("retrans_in_progress", retrans_in_progress, 0);
      end
    end
  end

  task automatic run_resp(input resp_case_t r);
    mac_ctrl_pkg::dur_t d;
    mac_ctrl_pkg::tx_word_t exp_w[3];
    logic [16:0] sig_bits;
    logic is_rts;
    int i;
    d = r.rand_dur ? mac_ctrl_pkg::dur_t'($urandom_range(40, 2000)) : r.dur;
    is_rts = (r.fc_type == T_CTRL) && (r.fc_sub == mac_ctrl_pkg::FC_SUB_RTS);
    @(posedge clk);
    clear_counts();
    cts_disable <= r.cts_off;
    send_frame(r.fc_type, r.fc_sub, r.more_frag, d, r.to_self ? SELF_ADDR : SELF_ADDR ^ 48'h1,
               is_rts ? mac_ctrl_pkg::RTS_LEN_BYTES : 12'd100, r.fcs_good);
    if (r.exp_resp) begin
      wait_for(E_START, E_NONE, 1, 40, "start_tx_ack");
      // credits trickle in with random gaps
      for (i = 0; i < 3; i++) begin
        repeat ($urandom_range(0, 3)) @(posedge clk);
        pulse(P_CREDIT);
      end
      wait_for(E_WORD, E_NONE, 3, 20, "third response word");
      pulse(P_TX_DONE);
      sig_bits = {mac_ctrl_pkg::ACK_LEN_BYTES, 1'b0, RATE};
      exp_w[0] = {46'd0, ^sig_bits, sig_bits};
      exp_w[1] = {PEER_ADDR[31:0], exp_duration(r, d), 8'h00,
                  is_rts ? mac_ctrl_pkg::FC_SUB_CTS : mac_ctrl_pkg::FC_SUB_ACK, T_CTRL, 2'b00};
      exp_w[2] = {48'd0, PEER_ADDR[47:32]};
      repeat (4) @(posedge clk);
      check_val("response word count", words.size(), 3);
      for (i = 0; i < 3; i++) begin
        if (i < words.size()) check_val($sformatf("tx_word[%0d]", i), words[i], exp_w[i]);
      end
    end else begin
      repeat (30) @(posedge clk);
    end
    check_val("start_tx_ack pulses", ev[E_START], r.exp_resp);
  endtask

  task automatic run_wait(input wait_case_t r);
    int tries;
    logic finished;
    @(posedge clk);
    clear_counts();
    tries = 0;
    finished = 1'b0;
    tx_need_ack   <= r.need_ack;
    retrans_limit <= r.limit;
    while (!finished && tries < 16) begin
      pulse(P_TX_DONE);
      if (!r.need_ack) begin
        wait_for(E_DONE, E_NONE, 1, 10, "tx_complete without ack");
        finished = 1'b1;
      end else begin
        pulse(P_BB_END);
        if (r.ack_back || r.give_sig) begin
          repeat (2) @(posedge clk);
          pulse(P_SIG);
        end
        if (r.ack_back) begin
          send_frame(T_CTRL, mac_ctrl_pkg::FC_SUB_ACK, 1'b0, '0, SELF_ADDR,
                     mac_ctrl_pkg::ACK_LEN_BYTES, 1'b1);
          wait_for(E_DONE, E_NONE, 1, 20, "tx_complete after the ack");
          finished = 1'b1;
        end else begin
          wait_for(E_TRIG, E_DONE, tries + 1, 150, "timeout outcome");
          if (ev[E_DONE] != 0) begin
            finished = 1'b1;
          end else if (r.quit) begin
            pulse(P_QUIT);
            wait_for(E_DONE, E_NONE, 1, 10, "tx_complete after quit");
            finished = 1'b1;
          end else begin
            pulse(P_BACKOFF);
            wait_for(E_RETRY, E_NONE, tries + 1, 10, "start_retrans");
          end
        end
      end
      tries = tries + 1;
    end
    repeat (2) @(posedge clk);
    tx_need_ack <= 1'b0;
    check_val("tx_complete pulses", ev[E_DONE], 1);
    check_val("tx_status.success", last_status.success, r.exp_success);
    check_val("tx_status.num_retrans", last_status.num_retrans, r.exp_retrans);
    check_val("retrans_trigger pulses", ev[E_TRIG], r.exp_retrans);
    check_val("start_retrans pulses", ev[E_RETRY], r.quit ? r.exp_retrans - 1 : r.exp_retrans);
  endtask

  initial begin
    void'($urandom(32'hccc7_6ccb));
    rstn <= 1'b0;
    rx_hdr <= '0;
    rx_strobe <= 1'b0;
    fcs_ok <= 1'b0;
    sig_valid <= 1'b0;
    sig_len <= '0;
    cts_disable <= 1'b0;
    phy_tx_done <= 1'b0;
    tx_need_ack <= 1'b0;
    bb_end <= 1'b0;
    backoff_done <= 1'b0;
    quit_retrans <= 1'b0;
    credit <= 1'b0;
    retrans_limit <= '0;
    errors = 0;
    n_checks = 0;
    clear_counts();
    // type, subtype, more_frag, random dur, dur, to self, fcs ok, cts off, answer
    resp_tab.push_back({T_DATA, 4'h0, 1'b0, 1'b0, 16'd200, 1'b1, 1'b1, 1'b0, 1'b1});
    resp_tab.push_back({T_DATA, 4'h0, 1'b1, 1'b1, 16'd0, 1'b1, 1'b1, 1'b0, 1'b1});
    resp_tab.push_back({T_CTRL, mac_ctrl_pkg::FC_SUB_RTS, 1'b0, 1'b0, 16'd300, 4'b1101});
    resp_tab.push_back({T_CTRL, mac_ctrl_pkg::FC_SUB_RTS, 1'b0, 1'b1, 16'd0, 4'b1101});
    resp_tab.push_back({T_CTRL, mac_ctrl_pkg::FC_SUB_RTS, 1'b0, 1'b0, 16'd30, 4'b1101});
    resp_tab.push_back({T_CTRL, mac_ctrl_pkg::FC_SUB_RTS, 1'b0, 1'b0, 16'd300, 4'b1110});
    resp_tab.push_back({T_DATA, 4'h0, 1'b0, 1'b0, 16'd200, 1'b0, 1'b1, 1'b0, 1'b0});
    resp_tab.push_back({T_DATA, 4'h0, 1'b0, 1'b0, 16'd200, 1'b1, 1'b0, 1'b0, 1'b0});
    resp_tab.push_back({T_MGMT, 4'h8, 1'b1, 1'b1, 16'd0, 1'b1, 1'b1, 1'b0, 1'b1});
    resp_tab.push_back({T_CTRL, mac_ctrl_pkg::FC_SUB_PSPOLL, 1'b0, 1'b0, 16'hc001, 4'b1101});
    resp_tab.push_back({T_CTRL, mac_ctrl_pkg::FC_SUB_BAR, 1'b0, 1'b0, 16'd100, 4'b1101});
    // need ack, ack back, sig only, quit, limit, success, retries
    wait_tab.push_back({1'b1, 1'b1, 1'b0, 1'b0, 4'd2, 1'b1, 4'd0});
    wait_tab.push_back({1'b0, 1'b0, 1'b0, 1'b0, 4'd2, 1'b1, 4'd0});
    wait_tab.push_back({1'b1, 1'b0, 1'b0, 1'b0, 4'd2, 1'b0, 4'd2});
    wait_tab.push_back({1'b1, 1'b0, 1'b1, 1'b0, 4'd2, 1'b0, 4'd2});
    wait_tab.push_back({1'b1, 1'b0, 1'b0, 1'b1, 4'd2, 1'b0, 4'd1});
    wait_tab.push_back({1'b1, 1'b0, 1'b0, 1'b0, 4'd0, 1'b0, 4'd0});
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check_val("start_tx_ack after reset", start_tx_ack, 0);
    check_val("word_valid after reset", word_valid, 0);
    check_val("tx_complete after reset", tx_complete, 0);
    check_val("retrans_in_progress after reset", retrans_in_progress, 0);
    check_val("retrans_trigger after reset", retrans_trigger, 0);
    check_val("start_retrans after reset", start_retrans, 0);
    foreach (resp_tab[i]) run_resp(resp_tab[i]);
    foreach (wait_tab[i]) run_wait(wait_tab[i]);
    repeat (4) @(posedge clk);
    $display("checks run %0d, errors %0d", n_checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // budget is twice the summed row limits
  initial begin
    int budget;
    @(posedge rstn);
    budget = 0;
    foreach (resp_tab[i]) budget = budget + 100;
    foreach (wait_tab[i]) budget = budget + (wait_tab[i].limit + 1) * 200;
    repeat (2 * budget) @(posedge clk);
    $display("ERROR: run did not finish within %0d cycles", 2 * budget);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- src.f
src/mac_ctrl_pkg.sv
src/frame_classifier.sv
src/ack_responder.sv
src/ack_waiter.sv
src/tx_control_top.sv
dv/tx_control_sva.sv
dv/tb_tx_control.sv
